//--- src/core_pkg.sv
/* Core package
   Shared widths, memory messages, pipeline stage records and the
   RV32 instruction formats used by the four-stage core */
package core_pkg;

  // Widths
  localparam int addr_w = 32;
  // Tag carries the fetch epoch only
  localparam int opaq_w = 1;

  // Memory request op
  localparam logic mem_rd = 1'b0;
  localparam logic mem_wr = 1'b1;

  // ------------------------------
  // RV32 encodings
  // ------------------------------
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_mul  = 7'b0000001;

  // ------------------------------
  // Memory messages
  // ------------------------------
  typedef struct packed {
    logic              op;
    logic [opaq_w-1:0] opaque;
    logic [addr_w-1:0] addr;
    logic [addr_w-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic              op;
    logic [opaq_w-1:0] opaque;
    logic [addr_w-1:0] data;
  } mem_resp_t;

  // One instruction word, five views
  typedef union packed {
    struct packed {
      logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm12; logic [4:0] rs1; logic [2:0] funct3;
      logic [4:0]  rd;    logic [6:0] opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi; logic [4:0] rs2;    logic [4:0] rs1;
      logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
      logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
      logic [4:0] rd; logic [6:0] opcode;
    } j_fmt;
  } inst_t;

  typedef enum logic [3:0] {
    op_addi, op_add, op_mul, op_lw, op_sw, op_jal, op_jalr, op_bne, op_nop
  } uop_e;

  // ------------------------------
  // Stage records
  // ------------------------------
  typedef struct packed {
    logic [addr_w-1:0] pc;
    inst_t             word;
  } f2d_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    uop_e              uop;
    logic [4:0]        rd;
    logic [addr_w-1:0] op_a;
    logic [addr_w-1:0] op_b;
    logic [addr_w-1:0] imm;
    logic [addr_w-1:0] st_data;
  } d2x_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    uop_e              uop;
    logic [4:0]        rd;
    logic [addr_w-1:0] result;
    logic [addr_w-1:0] st_data;
  } x2w_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [4:0]        waddr;
    logic [addr_w-1:0] wdata;
    logic              wen;
  } trace_t;

endpackage

//--- src/fetch_stage.sv
`timescale 1ns/1ps
/* Fetch stage
   Program counter and instruction memory requests, with a two-entry
   reply buffer and epoch tagging to drop wrong-path replies */
module fetch_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                redirect_val,
  input  logic [31:0]         redirect_pc,
  output core_pkg::mem_req_t  imem_req,
  output logic                imem_req_val,
  input  logic                imem_req_rdy,
  input  core_pkg::mem_resp_t imem_resp,
  input  logic                imem_resp_val,
  output logic                imem_resp_rdy,
  output core_pkg::f2d_t      f2d,
  output logic                f2d_val,
  input  logic                f2d_rdy
);

  logic [31:0]                 pc;
  logic [core_pkg::opaq_w-1:0] epoch;
  // Pcs of requests in flight, oldest at q_rd
  logic [31:0]                 pc_q [2];
  logic                        q_wr, q_rd;
  logic [1:0]                  infl_cnt;
  // Replies not yet taken by decode
  core_pkg::f2d_t              buf_q [2];
  logic                        b_wr, b_rd;
  logic [1:0]                  buf_cnt;
  logic [2:0]                  occ;
  logic                        req_fire, resp_ok, push, pop;
  core_pkg::f2d_t              resp_f2d;

  // Only ask when a reply is sure to find room
  assign occ          = {1'b0, infl_cnt} + {1'b0, buf_cnt};
  assign imem_req_val = (occ < 3'd2);
  assign imem_req     = '{op: core_pkg::mem_rd, opaque: epoch, addr: pc, data: '0};
  assign req_fire     = imem_req_val && imem_req_rdy;

  assign imem_resp_rdy = 1'b1;
  // Stale epoch or redirect this cycle means wrong path
  assign resp_ok = imem_resp_val && (imem_resp.opaque == epoch) && !redirect_val;

  always_comb begin
    resp_f2d.pc   = pc_q[q_rd];
    resp_f2d.word = imem_resp.data;
  end

  // Buffer head first, else the reply straight through
  assign f2d_val = (buf_cnt != 2'd0) || resp_ok;
  assign f2d     = (buf_cnt != 2'd0) ? buf_q[b_rd] : resp_f2d;
  assign push    = resp_ok && ((buf_cnt != 2'd0) || !f2d_rdy);
  assign pop     = (buf_cnt != 2'd0) && f2d_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc       <= '0;
      epoch    <= '0;
      q_wr     <= 1'b0;
      q_rd     <= 1'b0;
      infl_cnt <= 2'd0;
      b_wr     <= 1'b0;
      b_rd     <= 1'b0;
      buf_cnt  <= 2'd0;
    end else begin
      if (redirect_val) begin
        pc    <= redirect_pc;
        epoch <= ~epoch;
      end else if (req_fire) begin
        pc <= pc + 32'd4;
      end
      // In-flight count covers squashed requests too
      if (req_fire)      q_wr <= ~q_wr;
      if (imem_resp_val) q_rd <= ~q_rd;
      infl_cnt <= infl_cnt + {1'b0, req_fire} - {1'b0, imem_resp_val};
      if (redirect_val) begin
        b_wr    <= 1'b0;
        b_rd    <= 1'b0;
        buf_cnt <= 2'd0;
      end else begin
        if (push) b_wr <= ~b_wr;
        if (pop)  b_rd <= ~b_rd;
        buf_cnt <= buf_cnt + {1'b0, push} - {1'b0, pop};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) pc_q[q_wr] <= pc;
    if (push)     buf_q[b_wr] <= resp_f2d;
  end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps
/* Decode stage
   Instruction decode, register file with writeback bypass and a
   per-register busy scoreboard that holds back dependent instructions */
module decode_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  core_pkg::f2d_t f2d,
  input  logic           f2d_val,
  output logic           f2d_rdy,
  input  logic           squash,
  output core_pkg::d2x_t d2x,
  output logic           d2x_val,
  input  logic           d2x_rdy,
  input  logic           wb_val,
  input  logic [4:0]     wb_rd,
  input  logic [31:0]    wb_data
);

  core_pkg::f2d_t  held;
  logic            held_val;
  core_pkg::inst_t w;
  core_pkg::uop_e  uop;
  logic [31:0]     rf [32];
  logic [31:0]     busy;
  logic [31:0]     imm, rs1_v, rs2_v;
  logic [4:0]      rs1, rs2, rd_w;
  logic            use_rs1, use_rs2, stall, issue;

  assign w   = held.word;
  assign rs1 = w.r_fmt.rs1;
  assign rs2 = w.r_fmt.rs2;

  // ------------------------------
  // Opcode to uop
  // ------------------------------
  always_comb begin
    uop = core_pkg::op_nop;
    case (w.r_fmt.opcode)
      core_pkg::opc_op_imm:
        if (w.i_fmt.funct3 == core_pkg::f3_add) uop = core_pkg::op_addi;
      core_pkg::opc_op:
        if (w.r_fmt.funct3 == core_pkg::f3_add) begin
          if (w.r_fmt.funct7 == core_pkg::f7_base)     uop = core_pkg::op_add;
          else if (w.r_fmt.funct7 == core_pkg::f7_mul) uop = core_pkg::op_mul;
        end
      core_pkg::opc_load:
        if (w.i_fmt.funct3 == core_pkg::f3_word) uop = core_pkg::op_lw;
      core_pkg::opc_store:
        if (w.s_fmt.funct3 == core_pkg::f3_word) uop = core_pkg::op_sw;
      core_pkg::opc_jal:  uop = core_pkg::op_jal;
      core_pkg::opc_jalr:
        if (w.i_fmt.funct3 == core_pkg::f3_add) uop = core_pkg::op_jalr;
      core_pkg::opc_branch:
        if (w.b_fmt.funct3 == core_pkg::f3_bne) uop = core_pkg::op_bne;
      default: uop = core_pkg::op_nop;
    endcase
  end

  // Sources read and destination written, per uop
  always_comb begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    rd_w    = 5'd0;
    imm     = {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
    case (uop)
      core_pkg::op_addi, core_pkg::op_lw, core_pkg::op_jalr: begin
        use_rs1 = 1'b1;
        rd_w    = w.i_fmt.rd;
      end
      core_pkg::op_add, core_pkg::op_mul: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        rd_w    = w.r_fmt.rd;
      end
      core_pkg::op_sw: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
      end
      core_pkg::op_bne: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm     = {{19{w.b_fmt.imm_12}}, w.b_fmt.imm_12, w.b_fmt.imm_11,
                   w.b_fmt.imm_10_5, w.b_fmt.imm_4_1, 1'b0};
      end
      core_pkg::op_jal: begin
        rd_w = w.j_fmt.rd;
        imm  = {{11{w.j_fmt.imm_20}}, w.j_fmt.imm_20, w.j_fmt.imm_19_12,
                w.j_fmt.imm_11, w.j_fmt.imm_10_1, 1'b0};
      end
      default: imm = '0;
    endcase
  end

  // Register read, same-cycle writeback wins
  assign rs1_v = (rs1 == 5'd0) ? '0 : (wb_val && wb_rd == rs1) ? wb_data : rf[rs1];
  assign rs2_v = (rs2 == 5'd0) ? '0 : (wb_val && wb_rd == rs2) ? wb_data : rf[rs2];

  // Busy sources wait; busy rd waits too so writes land in order
  assign stall = (use_rs1 && busy[rs1] && !(wb_val && wb_rd == rs1)) ||
                 (use_rs2 && busy[rs2] && !(wb_val && wb_rd == rs2)) ||
                 (busy[rd_w] && !(wb_val && wb_rd == rd_w));

  assign d2x_val = held_val && !stall && !squash;
  assign issue   = d2x_val && d2x_rdy;
  assign f2d_rdy = !held_val || issue;
  assign d2x     = '{pc: held.pc, uop: uop, rd: rd_w, op_a: rs1_v,
                     op_b: (uop == core_pkg::op_addi) ? imm : rs2_v,
                     imm: imm, st_data: rs2_v};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_val <= 1'b0;
      busy     <= '0;
    end else begin
      if (squash)                  held_val <= 1'b0;
      else if (f2d_val && f2d_rdy) held_val <= 1'b1;
      else if (issue)              held_val <= 1'b0;
      // Clear then set, so a reissue of the same rd stays busy
      if (wb_val)                    busy[wb_rd] <= 1'b0;
      if (issue && rd_w != 5'd0)     busy[rd_w]  <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (f2d_val && f2d_rdy)      held <= f2d;
    if (wb_val && wb_rd != 5'd0) rf[wb_rd] <= wb_data;
  end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
/* Execute stage
   Adder, multiplier and branch/jump resolution in one cycle; taken
   control flow raises a one-cycle redirect to fetch */
module execute_stage (
  input  logic           clk,
  input  logic           rst_n,
  input  core_pkg::d2x_t d2x,
  input  logic           d2x_val,
  output logic           d2x_rdy,
  output core_pkg::x2w_t x2w,
  output logic           x2w_val,
  input  logic           x2w_rdy,
  output logic           redirect_val,
  output logic [31:0]    redirect_pc
);

  logic [31:0] sum, prod, addr, link, br_tgt, jalr_tgt;
  logic [31:0] result, target;
  logic        taken, accept;

  // ------------------------------
  // Datapath
  // ------------------------------
  assign sum  = d2x.op_a + d2x.op_b;
  // Low half is the same for signed and unsigned operands
  assign prod = d2x.op_a * d2x.op_b;
  assign addr = d2x.op_a + d2x.imm;
  assign link = d2x.pc + 32'd4;

  // Targets, jalr drops bit 0
  assign br_tgt   = d2x.pc + d2x.imm;
  assign jalr_tgt = {addr[31:1], 1'b0};

  always_comb begin
    result = '0;
    taken  = 1'b0;
    target = br_tgt;
    case (d2x.uop)
      core_pkg::op_addi, core_pkg::op_add: result = sum;
      core_pkg::op_mul:                    result = prod;
      core_pkg::op_lw, core_pkg::op_sw:    result = addr;
      core_pkg::op_jal: begin
        result = link;
        taken  = 1'b1;
      end
      core_pkg::op_jalr: begin
        result = link;
        taken  = 1'b1;
        target = jalr_tgt;
      end
      core_pkg::op_bne: taken = (d2x.op_a != d2x.op_b);
      default: result = '0;
    endcase
  end

  // ------------------------------
  // Handshake
  // ------------------------------
  assign d2x_rdy = !x2w_val || x2w_rdy;
  // Whatever shows up behind a redirect is wrong path
  assign accept  = d2x_val && d2x_rdy && !redirect_val;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x2w_val      <= 1'b0;
      redirect_val <= 1'b0;
    end else begin
      if (accept)       x2w_val <= 1'b1;
      else if (x2w_rdy) x2w_val <= 1'b0;
      // Single-cycle pulse
      redirect_val <= accept && taken;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      x2w         <= '{pc: d2x.pc, uop: d2x.uop, rd: d2x.rd, result: result,
                       st_data: d2x.st_data};
      redirect_pc <= target;
    end
  end

endmodule

//--- src/mem_wb_stage.sv
`timescale 1ns/1ps
/* Memory and writeback stage
   Data memory access for lw/sw, register writeback to decode and
   the retirement trace, one record per instruction in order */
module mem_wb_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  core_pkg::x2w_t      x2w,
  input  logic                x2w_val,
  output logic                x2w_rdy,
  output core_pkg::mem_req_t  dmem_req,
  output logic                dmem_req_val,
  input  logic                dmem_req_rdy,
  input  core_pkg::mem_resp_t dmem_resp,
  input  logic                dmem_resp_val,
  output logic                dmem_resp_rdy,
  output logic                wb_val,
  output logic [4:0]          wb_rd,
  output logic [31:0]         wb_data,
  output core_pkg::trace_t    trace,
  output logic                trace_val
);

  typedef enum logic [1:0] {st_idle, st_req, st_wait} state_e;

  state_e           state;
  core_pkg::x2w_t   cur;
  core_pkg::trace_t ret_rec;
  logic             accept, is_mem, is_sw, ret_val;

  assign x2w_rdy = (state == st_idle);
  assign accept  = x2w_val && x2w_rdy;
  assign is_mem  = (x2w.uop == core_pkg::op_lw) || (x2w.uop == core_pkg::op_sw);
  assign is_sw   = (cur.uop == core_pkg::op_sw);

  // ------------------------------
  // Data memory port
  // ------------------------------
  assign dmem_req_val  = (state == st_req);
  assign dmem_req      = '{op: is_sw ? core_pkg::mem_wr : core_pkg::mem_rd,
                           opaque: '0, addr: cur.result, data: cur.st_data};
  assign dmem_resp_rdy = (state == st_wait);

  // Retire either a plain op now or a memory op on its response
  always_comb begin
    ret_val = 1'b0;
    ret_rec = '{pc: x2w.pc, waddr: x2w.rd, wdata: x2w.result, wen: x2w.rd != 5'd0};
    if (state == st_wait) begin
      ret_val = dmem_resp_val;
      ret_rec = '{pc: cur.pc, waddr: cur.rd,
                  wdata: is_sw ? '0 : dmem_resp.data,
                  wen: !is_sw && cur.rd != 5'd0};
    end else if (accept && !is_mem) begin
      ret_val = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      trace_val <= 1'b0;
    end else begin
      trace_val <= ret_val;
      case (state)
        st_idle: if (accept && is_mem) state <= st_req;
        st_req:  if (dmem_req_rdy)     state <= st_wait;
        st_wait: if (dmem_resp_val)    state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept)  cur   <= x2w;
    if (ret_val) trace <= ret_rec;
  end

  // Writeback follows the retired record
  assign wb_val  = trace_val && trace.wen;
  assign wb_rd   = trace.waddr;
  assign wb_data = trace.wdata;

endmodule

//--- src/core_top.sv
`timescale 1ns/1ps
/* Core top
   Four-stage RV32 pipeline: fetch, decode, execute, memory/writeback */
module core_top (
  input  logic                clk,
  input  logic                rst_n,
  output core_pkg::mem_req_t  imem_req,
  output logic                imem_req_val,
  input  logic                imem_req_rdy,
  input  core_pkg::mem_resp_t imem_resp,
  input  logic                imem_resp_val,
  output logic                imem_resp_rdy,
  output core_pkg::mem_req_t  dmem_req,
  output logic                dmem_req_val,
  input  logic                dmem_req_rdy,
  input  core_pkg::mem_resp_t dmem_resp,
  input  logic                dmem_resp_val,
  output logic                dmem_resp_rdy,
  output core_pkg::trace_t    trace,
  output logic                trace_val
);

  core_pkg::f2d_t f2d;
  core_pkg::d2x_t d2x;
  core_pkg::x2w_t x2w;
  logic           f2d_val, f2d_rdy, d2x_val, d2x_rdy, x2w_val, x2w_rdy;
  // Control back-links
  logic           redirect_val, wb_val;
  logic [31:0]    redirect_pc, wb_data;
  logic [4:0]     wb_rd;

  fetch_stage fetch_i (
    .clk, .rst_n, .redirect_val, .redirect_pc,
    .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .f2d, .f2d_val, .f2d_rdy
  );

  decode_stage decode_i (
    .clk, .rst_n, .f2d, .f2d_val, .f2d_rdy, .squash(redirect_val),
    .d2x, .d2x_val, .d2x_rdy, .wb_val, .wb_rd, .wb_data
  );

  execute_stage execute_i (
    .clk, .rst_n, .d2x, .d2x_val, .d2x_rdy,
    .x2w, .x2w_val, .x2w_rdy, .redirect_val, .redirect_pc
  );

  mem_wb_stage mem_wb_i (
    .clk, .rst_n, .x2w, .x2w_val, .x2w_rdy,
    .dmem_req, .dmem_req_val, .dmem_req_rdy,
    .dmem_resp, .dmem_resp_val, .dmem_resp_rdy,
    .wb_val, .wb_rd, .wb_data, .trace, .trace_val
  );

endmodule

//--- sim/test_mem.sv
`timescale 1ns/1ps
/* Test memory
   Shared instruction and data memory behind two request/response ports,
   in-order replies with optional xorshift-random ready and reply delays */
module test_mem (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rand_en,
  input  logic [31:0]         fetch_limit,
  input  logic                ld_en,
  input  logic [7:0]          ld_addr,
  input  logic [31:0]         ld_data,
  input  core_pkg::mem_req_t  imem_req,
  input  logic                imem_req_val,
  output logic                imem_req_rdy,
  output core_pkg::mem_resp_t imem_resp,
  output logic                imem_resp_val,
  input  logic                imem_resp_rdy,
  input  core_pkg::mem_req_t  dmem_req,
  input  logic                dmem_req_val,
  output logic                dmem_req_rdy,
  output core_pkg::mem_resp_t dmem_resp,
  output logic                dmem_resp_val,
  input  logic                dmem_resp_rdy
);

  logic [31:0]               mem [256];
  logic [31:0]               rng;
  logic [7:0]                idx;
  // Port 0 is instruction side, port 1 data side
  core_pkg::mem_req_t  [1:0] req;
  core_pkg::mem_resp_t [1:0] resp;
  logic [1:0]                req_val, rdy, rdy_r, resp_val, resp_rdy;
  // Pending replies per port, circular
  core_pkg::mem_resp_t       rq [2][4];
  int                        due [2][4];
  int                        head [2];
  int                        tail [2];
  int                        cnt [2];
  int                        cyc;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    xorshift = y ^ (y << 5);
  endfunction

  initial rng = 32'd38;

  assign req      = {dmem_req, imem_req};
  assign req_val  = {dmem_req_val, imem_req_val};
  assign resp_rdy = {dmem_resp_rdy, imem_resp_rdy};
  // Fetches past the end of the program stall forever
  assign rdy = {rdy_r[1], rdy_r[0] && (imem_req.addr < fetch_limit)};

  assign imem_req_rdy  = rdy[0];
  assign dmem_req_rdy  = rdy[1];
  assign imem_resp     = resp[0];
  assign dmem_resp     = resp[1];
  assign imem_resp_val = resp_val[0];
  assign dmem_resp_val = resp_val[1];

  // Preload port, works during reset
  always @(posedge clk) begin
    if (ld_en) mem[ld_addr] <= ld_data;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_r    <= 2'b11;
      resp_val <= 2'b00;
      resp     <= '0;
      for (int p = 0; p < 2; p++) begin
        head[p] = 0;
        tail[p] = 0;
        cnt[p]  = 0;
      end
      cyc = 0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        rng = xorshift(rng);
        // Head reply taken by the core
        if (resp_val[p] && resp_rdy[p]) begin
          head[p] = (head[p] + 1) % 4;
          cnt[p]  = cnt[p] - 1;
        end
        // New request, stores land right away
        if (req_val[p] && rdy[p]) begin
          idx = req[p].addr[9:2];
          if (req[p].op == core_pkg::mem_wr) mem[idx] <= req[p].data;
          rq[p][tail[p]]  = '{op: req[p].op, opaque: req[p].opaque, data: mem[idx]};
          due[p][tail[p]] = cyc + (rand_en ? int'(rng[3:2]) : 0);
          tail[p]         = (tail[p] + 1) % 4;
          cnt[p]          = cnt[p] + 1;
        end
        // Oldest reply shows once its delay is over
        resp_val[p] <= (cnt[p] != 0) && (due[p][head[p]] <= cyc);
        resp[p]     <= rq[p][head[p]];
        rdy_r[p]    <= (cnt[p] < 3) && (!rand_en || rng[5:4] != 2'b00);
      end
      cyc = cyc + 1;
    end
  end

endmodule

//--- sim/core_tb.sv
`timescale 1ns/1ps
/* Core testbench
   Runs a table of small programs on the core, first with fixed and then
   with random memory delays, and checks every retirement in order */
module core_tb;

  logic                clk;
  logic                rst_n;
  logic                rand_en;
  logic [31:0]         fetch_limit;
  logic                ld_en;
  logic [7:0]          ld_addr;
  logic [31:0]         ld_data;
  core_pkg::mem_req_t  imem_req, dmem_req;
  core_pkg::mem_resp_t imem_resp, dmem_resp;
  logic                imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy;
  logic                dmem_req_val, dmem_req_rdy, dmem_resp_val, dmem_resp_rdy;
  core_pkg::trace_t    trace;
  logic                trace_val;

  // ------------------------------
  // Test table
  // ------------------------------
  string               t_name [8];
  int                  t_len [8];
  int                  t_nexp [8];
  logic [31:0]         t_prog [8][8];
  // Two data words at byte 0x100
  logic [31:0]         t_data [8][2];
  core_pkg::trace_t    t_exp [8][8];
  int                  n_tests;
  int                  cur;
  int                  errors;
  int                  wd_cycles;

  core_top dut_i (
    .clk, .rst_n,
    .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .dmem_req, .dmem_req_val, .dmem_req_rdy,
    .dmem_resp, .dmem_resp_val, .dmem_resp_rdy,
    .trace, .trace_val
  );

  test_mem mem_i (
    .clk, .rst_n, .rand_en, .fetch_limit, .ld_en, .ld_addr, .ld_data,
    .imem_req, .imem_req_val, .imem_req_rdy,
    .imem_resp, .imem_resp_val, .imem_resp_rdy,
    .dmem_req, .dmem_req_val, .dmem_req_rdy,
    .dmem_resp, .dmem_resp_val, .dmem_resp_rdy
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // RV32 encoders, straight from the ISA formats
  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    addi = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction
  function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
    add = {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction
  function automatic logic [31:0] mul(input int rd, input int rs1, input int rs2);
    mul = {7'b0000001, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction
  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    lw = {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction
  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    sw = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction
  function automatic logic [31:0] jal(input int rd, input int imm);
    jal = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction
  function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
    jalr = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
  endfunction
  function automatic logic [31:0] bne(input int rs1, input int rs2, input int imm);
    bne = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic open_test(input string name, input logic [31:0] d0, input logic [31:0] d1);
    cur = n_tests;
    n_tests = n_tests + 1;
    t_name[cur]    = name;
    t_len[cur]     = 0;
    t_nexp[cur]    = 0;
    t_data[cur][0] = d0;
    t_data[cur][1] = d1;
  endtask

  task automatic emit(input logic [31:0] word);
    t_prog[cur][t_len[cur]] = word;
    t_len[cur] = t_len[cur] + 1;
  endtask

  task automatic retire(input logic [31:0] pc, input logic [4:0] rd,
                        input logic [31:0] data, input logic wen);
    t_exp[cur][t_nexp[cur]] = '{pc: pc, waddr: rd, wdata: data, wen: wen};
    t_nexp[cur] = t_nexp[cur] + 1;
  endtask

  task automatic build_table();
    // Dependent sums, x0 write
    open_test("addi_add_chain", 32'h0, 32'h0);
    emit(addi(1, 0, 5));   emit(addi(2, 1, -3));  emit(add(3, 1, 2));
    emit(add(3, 3, 3));    emit(addi(0, 3, 1));   emit(add(4, 3, 1));
    retire(0, 1, 5, 1);    retire(4, 2, 2, 1);    retire(8, 3, 7, 1);
    retire(12, 3, 14, 1);  retire(16, 0, 0, 0);   retire(20, 4, 19, 1);
    // Low product, signed operands
    open_test("mul_signed", 32'h0, 32'h0);
    emit(addi(1, 0, -7));  emit(addi(2, 0, 6));   emit(mul(3, 1, 2));
    emit(mul(4, 1, 1));    emit(addi(5, 0, 1000)); emit(mul(6, 5, 5));
    emit(mul(7, 6, 6));
    retire(0, 1, 32'hFFFF_FFF9, 1);  retire(4, 2, 6, 1);  retire(8, 3, 32'hFFFF_FFD6, 1);
    retire(12, 4, 49, 1);  retire(16, 5, 1000, 1);  retire(20, 6, 1000000, 1);
    retire(24, 7, 32'hD4A5_1000, 1);
    // Store then load, preloaded words
    open_test("store_load", 32'h1234_5678, 32'hCAFE_F00D);
    emit(addi(1, 0, 256)); emit(addi(2, 0, -1));  emit(sw(2, 1, 8));
    emit(lw(3, 1, 8));     emit(lw(4, 1, 0));     emit(add(5, 3, 4));
    emit(sw(5, 1, 4));     emit(lw(6, 1, 4));
    retire(0, 1, 32'h100, 1);  retire(4, 2, 32'hFFFF_FFFF, 1);  retire(8, 0, 0, 0);
    retire(12, 3, 32'hFFFF_FFFF, 1);  retire(16, 4, 32'h1234_5678, 1);
    retire(20, 5, 32'h1234_5677, 1);  retire(24, 0, 0, 0);
    retire(28, 6, 32'h1234_5677, 1);
    // Taken bne hides pc 8
    open_test("bne_skip", 32'h0, 32'h0);
    emit(addi(1, 0, 1));   emit(bne(1, 0, 8));    emit(addi(2, 0, 99));
    emit(bne(1, 1, 8));    emit(addi(3, 0, 7));   emit(addi(4, 3, 1));
    retire(0, 1, 1, 1);    retire(4, 0, 0, 0);    retire(12, 0, 0, 0);
    retire(16, 3, 7, 1);   retire(20, 4, 8, 1);
    // Backward branch, two trips
    open_test("bne_loop", 32'h0, 32'h0);
    emit(addi(1, 0, 2));   emit(addi(1, 1, -1));  emit(bne(1, 0, -4));
    emit(addi(2, 0, 5));
    retire(0, 1, 2, 1);    retire(4, 1, 1, 1);    retire(8, 0, 0, 0);
    retire(4, 1, 0, 1);    retire(8, 0, 0, 0);    retire(12, 2, 5, 1);
    // Links, jalr to odd address 5 lands on 4
    open_test("jal_jalr", 32'h0, 32'h0);
    emit(jal(1, 12));      emit(addi(2, 0, 33));  emit(jal(0, 12));
    emit(addi(3, 1, 1));   emit(jalr(4, 3, 0));   emit(addi(6, 4, 2));
    retire(0, 1, 4, 1);    retire(12, 3, 5, 1);   retire(16, 4, 20, 1);
    retire(4, 2, 33, 1);   retire(8, 0, 0, 0);    retire(20, 6, 22, 1);
  endtask

  task automatic stop_run(input string why);
    errors = errors + 1;
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
      stop_run($sformatf("FAILED %s: expected %h, actual %h", what, expected, actual));
  endtask

  task automatic run_test(input int t, input logic rnd);
    int               n;
    int               waited;
    string            tag;
    core_pkg::trace_t got;
    // Load while fetch is held off by a zero limit
    for (int i = 0; i < t_len[t]; i++) begin
      @(posedge clk);
      fetch_limit <= '0;
      ld_en       <= 1'b1;
      ld_addr     <= i[7:0];
      ld_data     <= t_prog[t][i];
    end
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      ld_addr <= 8'd64 + i[7:0];
      ld_data <= t_data[t][i];
    end
    @(posedge clk);
    ld_en       <= 1'b0;
    rst_n       <= 1'b0;
    rand_en     <= rnd;
    fetch_limit <= t_len[t] * 4;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Compare each retirement in program order
    n = 0;
    waited = 0;
    while (n < t_nexp[t]) begin
      @(negedge clk);
      waited = waited + 1;
      if (trace_val) begin
        got = trace;
        tag = $sformatf("%s (%s delays) retirement %0d", t_name[t], rnd ? "random" : "fixed", n);
        check({tag, " pc"}, t_exp[t][n].pc, got.pc);
        check({tag, " wen"}, t_exp[t][n].wen, got.wen);
        check({tag, " waddr"}, t_exp[t][n].waddr, got.waddr);
        if (t_exp[t][n].wen) begin
          check({tag, " wdata"}, t_exp[t][n].wdata, got.wdata);
        end
        n = n + 1;
      end else if (waited > t_len[t] * 40 + 100) begin
        stop_run($sformatf("Test %s: only %0d of %0d instructions retired",
                           t_name[t], n, t_nexp[t]));
      end
    end
    // Program has run out, nothing more may retire
    repeat (30) begin
      @(negedge clk);
      if (trace_val)
        stop_run($sformatf("Test %s: extra retirement at pc %h", t_name[t], trace.pc));
    end
  endtask

  // Watchdog
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    stop_run("Timeout: the run did not finish in the allowed number of cycles");
  end

  initial begin
    rst_n       = 1'b0;
    rand_en     = 1'b0;
    fetch_limit = '0;
    ld_en       = 1'b0;
    ld_addr     = '0;
    ld_data     = '0;
    errors      = 0;
    n_tests     = 0;
    wd_cycles   = 0;
    build_table();
    // Both passes count toward the limit
    for (int t = 0; t < n_tests; t++) wd_cycles = wd_cycles + 2 * t_len[t] * 40;
    wd_cycles = wd_cycles + 200;
    for (int pass = 0; pass < 2; pass++) begin
      for (int t = 0; t < n_tests; t++) run_test(t, pass == 1);
    end
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
src/core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/core_top.sv
sim/test_mem.sv
sim/core_tb.sv
